// ==== source/rv_core_defines.svh ====
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data and address width of the core
`define RV_XLEN 32

`define RV_NR_REGS 32

// Program counter after reset, also loaded into x5
`define RV_RESET_PC 32'h2040_0000

`endif

// ==== source/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    // Shared by register and immediate arithmetic, funct7 bit 5 picks SUB and SRA
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_funct3_t;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_funct3_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

endpackage

`default_nettype wire

// ==== source/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_PREPARE,
        ST_EXECUTE,
        ST_ACCESS,
        ST_WRITEBACK
    } stage_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_t;

    // Encoded as the low two funct3 bits of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        WB_ALU, WB_IMM, WB_LINK, WB_LOAD
    } wb_sel_t;

endpackage

`default_nettype wire

// ==== source/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_core_defines.svh"
`default_nettype none

module rv_decoder
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_en,
    input  instr_u              i_instr,
    output logic [4:0]          o_rs1,
    output logic [4:0]          o_rs2,
    output logic [4:0]          o_rd,
    output logic [`RV_XLEN-1:0] o_imm,
    output alu_op_t             o_alu_op,
    output br_op_t              o_br_op,
    output logic                o_use_pc,
    output logic                o_use_imm,
    output logic                o_use_shamt,
    output logic                o_is_load,
    output logic                o_is_store,
    output logic                o_is_jump,
    output mem_size_t           o_mem_size,
    output logic                o_load_unsigned,
    output wb_sel_t             o_wb_sel,
    output logic                o_rd_we
);

    opcode_t    opcode;
    logic [2:0] funct3;

    assign opcode = i_instr.r.opcode;
    assign funct3 = i_instr.r.funct3;

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt,
                                         input logic reg_op);
        case (alu_funct3_t'(f3))
            F3_ADD:  return (alt && reg_op) ? ALU_SUB : ALU_ADD; // ADDI has no SUB form
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic br_op_t branch_op(input logic [2:0] f3);
        case (br_funct3_t'(f3))
            F3_BEQ:  return BR_EQ;
            F3_BNE:  return BR_NE;
            F3_BLT:  return BR_LT;
            F3_BGE:  return BR_GE;
            F3_BLTU: return BR_LTU;
            F3_BGEU: return BR_GEU;
            default: return BR_NONE;
        endcase
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_rs1 <= i_instr.r.rs1;
            o_rs2 <= i_instr.r.rs2;
            o_rd  <= i_instr.r.rd;
            o_use_pc    <= opcode inside {OP_AUIPC, OP_JAL, OP_BRANCH};
            o_use_imm   <= opcode != OP_REG;
            o_use_shamt <= (opcode == OP_IMM) && (funct3[1:0] == 2'b01);
            o_mem_size  <= mem_size_t'(funct3[1:0]);
            o_load_unsigned <= funct3[2];
            o_alu_op <= (opcode inside {OP_REG, OP_IMM}) ?
                        arith_op(funct3, i_instr.r.funct7[5], opcode == OP_REG) : ALU_ADD;

            case (opcode)
                OP_LUI:  o_wb_sel <= WB_IMM;
                OP_JAL, OP_JALR: o_wb_sel <= WB_LINK;
                OP_LOAD: o_wb_sel <= WB_LOAD;
                default: o_wb_sel <= WB_ALU;
            endcase

            case (opcode)
                OP_STORE: o_imm <= {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
                OP_BRANCH: o_imm <= {{20{i_instr.b.imm_12}}, i_instr.b.imm_11,
                                     i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
                OP_LUI, OP_AUIPC: o_imm <= {i_instr.u.imm, 12'b0};
                OP_JAL: o_imm <= {{12{i_instr.j.imm_20}}, i_instr.j.imm_19_12,
                                  i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};
                // Unknown opcodes run as I-type
                default: o_imm <= {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_is_load  <= 1'b0;
            o_is_store <= 1'b0;
            o_is_jump  <= 1'b0;
            o_br_op    <= BR_NONE;
            o_rd_we    <= 1'b0;
        end else if (i_en) begin
            o_is_load  <= opcode == OP_LOAD;
            o_is_store <= opcode == OP_STORE;
            o_is_jump  <= opcode inside {OP_JAL, OP_JALR};
            o_br_op    <= (opcode == OP_BRANCH) ? branch_op(funct3) : BR_NONE;
            o_rd_we    <= !(opcode inside {OP_BRANCH, OP_STORE}) && (i_instr.r.rd != 5'd0);
        end
    end

endmodule

`default_nettype wire

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_core_defines.svh"
`default_nettype none

module rv_regfile #(
    parameter logic [`RV_XLEN-1:0] RESET_PC = `RV_RESET_PC
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [4:0]          i_rs1,
    input  logic [4:0]          i_rs2,
    output logic [`RV_XLEN-1:0] o_rs1_data,
    output logic [`RV_XLEN-1:0] o_rs2_data,
    input  logic                i_we,
    input  logic [4:0]          i_rd,
    input  logic [`RV_XLEN-1:0] i_wd
);

    logic [`RV_XLEN-1:0] regs [`RV_NR_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NR_REGS; i++) begin
                regs[i] <= (i == 5) ? RESET_PC : '0; // x5 starts out holding the boot address
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wd;
        end
    end

    assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== source/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_core_defines.svh"
`default_nettype none

module rv_alu
    import rv_core_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_op_en,
    input  logic                i_ex_en,
    input  logic [`RV_XLEN-1:0] i_pc,
    input  logic [`RV_XLEN-1:0] i_rs1_data,
    input  logic [`RV_XLEN-1:0] i_rs2_data,
    input  logic [`RV_XLEN-1:0] i_imm,
    input  logic [4:0]          i_shamt,
    input  logic                i_use_pc,
    input  logic                i_use_imm,
    input  logic                i_use_shamt,
    input  alu_op_t             i_alu_op,
    input  br_op_t              i_br_op,
    output logic [`RV_XLEN-1:0] o_result,
    output logic                o_take_branch
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] cmp_a;
    logic [`RV_XLEN-1:0] cmp_b;
    logic [`RV_XLEN-1:0] result;
    logic                take;

    // Branches add pc and offset while comparing the register pair separately
    always_ff @(posedge i_clk) begin
        if (i_op_en) begin
            op_a  <= i_use_pc ? i_pc : i_rs1_data;
            op_b  <= i_use_shamt ? {{(`RV_XLEN-5){1'b0}}, i_shamt} :
                     i_use_imm ? i_imm : i_rs2_data;
            cmp_a <= i_rs1_data;
            cmp_b <= i_rs2_data;
        end
    end

    always_comb begin
        case (i_alu_op)
            ALU_SUB:  result = op_a - op_b;
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_SLL:  result = op_a << op_b[4:0];
            ALU_SRL:  result = op_a >> op_b[4:0];
            ALU_SRA:  result = $signed(op_a) >>> op_b[4:0];
            default:  result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (i_br_op)
            BR_EQ:   take = cmp_a == cmp_b;
            BR_NE:   take = cmp_a != cmp_b;
            BR_LT:   take = $signed(cmp_a) < $signed(cmp_b);
            BR_GE:   take = $signed(cmp_a) >= $signed(cmp_b);
            BR_LTU:  take = cmp_a < cmp_b;
            BR_GEU:  take = cmp_a >= cmp_b;
            default: take = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_ex_en) begin
            o_result      <= result;
            o_take_branch <= take;
        end
    end

endmodule

`default_nettype wire

// ==== source/rv_lsu.sv ====
`timescale 1ns/1ps
`include "rv_core_defines.svh"
`default_nettype none

module rv_lsu
    import rv_core_pkg::*;
(
    input  logic [`RV_XLEN-1:0] i_addr,
    input  logic [`RV_XLEN-1:0] i_rs2_data,
    input  mem_size_t           i_size,
    input  logic                i_unsigned,
    input  logic [`RV_XLEN-1:0] i_rdata,
    output logic [`RV_XLEN-1:0] o_wdata,
    output logic [3:0]          o_wen,
    output logic [`RV_XLEN-1:0] o_load_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // The data is copied to every lane and the mask picks the one that is written
    always_comb begin
        case (i_size)
            MEM_BYTE: begin
                o_wdata = {4{i_rs2_data[7:0]}};
                o_wen   = 4'b0001 << i_addr[1:0];
            end
            MEM_HALF: begin
                o_wdata = {2{i_rs2_data[15:0]}};
                o_wen   = i_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                o_wdata = i_rs2_data;
                o_wen   = 4'b1111;
            end
        endcase
    end

    assign load_byte = i_rdata[{i_addr[1:0], 3'b000} +: 8];
    assign load_half = i_addr[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb begin
        case (i_size)
            MEM_BYTE: o_load_data = {{24{load_byte[7] & ~i_unsigned}}, load_byte};
            MEM_HALF: o_load_data = {{16{load_half[15] & ~i_unsigned}}, load_half};
            default:  o_load_data = i_rdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/rv_sequencer.sv ====
`timescale 1ns/1ps
`include "rv_core_defines.svh"
`default_nettype none

module rv_sequencer
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
#(
    parameter logic [`RV_XLEN-1:0] RESET_PC = `RV_RESET_PC
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_mem_ready,
    input  logic [`RV_XLEN-1:0] i_mem_rdata,
    input  logic                i_is_load,
    input  logic                i_is_store,
    input  logic                i_is_jump,
    input  logic                i_take_branch,
    input  logic [`RV_XLEN-1:0] i_alu_result,
    input  logic [`RV_XLEN-1:0] i_lsu_wdata,
    input  logic [3:0]          i_lsu_wen,
    output logic                o_mem_valid,
    output logic [`RV_XLEN-1:0] o_mem_addr,
    output logic [`RV_XLEN-1:0] o_mem_data,
    output logic [3:0]          o_mem_wen,
    output instr_u              o_instr,
    output logic [`RV_XLEN-1:0] o_rdata,
    output logic [`RV_XLEN-1:0] o_pc,
    output logic [`RV_XLEN-1:0] o_link,
    output logic                o_dec_en,
    output logic                o_op_en,
    output logic                o_ex_en,
    output logic                o_wb_en
);

    stage_t              stage;
    logic                issue;
    logic                capture;
    logic                retire;
    logic [`RV_XLEN-1:0] next_pc;

    assign issue   = (stage inside {ST_FETCH, ST_ACCESS}) && !o_mem_valid;
    assign capture = o_mem_valid && i_mem_ready;
    assign retire  = (stage == ST_WRITEBACK) || (stage == ST_ACCESS && capture && i_is_store);
    assign next_pc = (i_is_jump || i_take_branch) ? {i_alu_result[`RV_XLEN-1:1], 1'b0} : o_link;

    assign o_dec_en = stage == ST_DECODE;
    assign o_op_en  = stage == ST_PREPARE;
    assign o_ex_en  = stage == ST_EXECUTE;
    assign o_wb_en  = stage == ST_WRITEBACK;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage       <= ST_FETCH;
            o_mem_valid <= 1'b0;
            o_mem_wen   <= '0;
            o_pc        <= RESET_PC;
            o_link      <= RESET_PC + 'd4;
        end else begin
            if (issue) begin
                o_mem_valid <= 1'b1;
                o_mem_wen   <= (stage == ST_ACCESS && i_is_store) ? i_lsu_wen : 4'b0000;
            end else if (capture) begin
                o_mem_valid <= 1'b0;
                o_mem_wen   <= '0;
            end

            case (stage)
                ST_FETCH:   if (capture) stage <= ST_DECODE;
                ST_DECODE:  stage <= ST_PREPARE;
                ST_PREPARE: stage <= ST_EXECUTE;
                ST_EXECUTE: stage <= (i_is_load || i_is_store) ? ST_ACCESS : ST_WRITEBACK;
                // Stores retire here
                ST_ACCESS:  if (capture) stage <= i_is_store ? ST_FETCH : ST_WRITEBACK;
                default:    stage <= ST_FETCH;
            endcase

            if (retire) begin
                o_pc   <= next_pc;
                o_link <= next_pc + 'd4;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_mem_addr <= (stage == ST_FETCH) ? o_pc : i_alu_result;
        end
        if (issue && stage == ST_ACCESS) begin
            o_mem_data <= i_lsu_wdata;
        end
        if (capture && stage == ST_FETCH) begin
            o_instr <= i_mem_rdata;
        end
        if (capture && stage == ST_ACCESS) begin
            o_rdata <= i_mem_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_defines.svh"
`default_nettype none

module rv_core
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
#(
    parameter logic [`RV_XLEN-1:0] RESET_PC = `RV_RESET_PC
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_mem_ready,
    input  logic [`RV_XLEN-1:0] i_mem_data,
    output logic                o_mem_valid,
    output logic [`RV_XLEN-1:0] o_mem_addr,
    output logic [`RV_XLEN-1:0] o_mem_data,
    output logic [3:0]          o_mem_wen
);

    instr_u              instr;
    logic [`RV_XLEN-1:0] rdata, pc, link, imm, rs1_data, rs2_data;
    logic [`RV_XLEN-1:0] alu_result, lsu_wdata, load_data, wb_data;
    logic [4:0]          rs1, rs2, rd;
    logic [3:0]          lsu_wen;
    logic                dec_en, op_en, ex_en, wb_en, take_branch;
    logic                use_pc, use_imm, use_shamt, is_load, is_store, is_jump;
    logic                load_unsigned, rd_we;
    alu_op_t             alu_op;
    br_op_t              br_op;
    mem_size_t           mem_size;
    wb_sel_t             wb_sel;

    rv_sequencer #(.RESET_PC(RESET_PC)) rv_sequencer_inst (
        .i_clk, .i_rst, .i_mem_ready, .i_mem_rdata(i_mem_data),
        .i_is_load(is_load), .i_is_store(is_store), .i_is_jump(is_jump),
        .i_take_branch(take_branch), .i_alu_result(alu_result),
        .i_lsu_wdata(lsu_wdata), .i_lsu_wen(lsu_wen),
        .o_mem_valid, .o_mem_addr, .o_mem_data, .o_mem_wen,
        .o_instr(instr), .o_rdata(rdata), .o_pc(pc), .o_link(link),
        .o_dec_en(dec_en), .o_op_en(op_en), .o_ex_en(ex_en), .o_wb_en(wb_en)
    );

    rv_decoder rv_decoder_inst (
        .i_clk, .i_rst, .i_en(dec_en), .i_instr(instr),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(alu_op), .o_br_op(br_op),
        .o_use_pc(use_pc), .o_use_imm(use_imm), .o_use_shamt(use_shamt),
        .o_is_load(is_load), .o_is_store(is_store), .o_is_jump(is_jump),
        .o_mem_size(mem_size), .o_load_unsigned(load_unsigned),
        .o_wb_sel(wb_sel), .o_rd_we(rd_we)
    );

    rv_regfile #(.RESET_PC(RESET_PC)) rv_regfile_inst (
        .i_clk, .i_rst, .i_rs1(rs1), .i_rs2(rs2),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_we(wb_en && rd_we), .i_rd(rd), .i_wd(wb_data)
    );

    rv_alu rv_alu_inst (
        .i_clk, .i_op_en(op_en), .i_ex_en(ex_en), .i_pc(pc),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm), .i_shamt(rs2),
        .i_use_pc(use_pc), .i_use_imm(use_imm), .i_use_shamt(use_shamt),
        .i_alu_op(alu_op), .i_br_op(br_op),
        .o_result(alu_result), .o_take_branch(take_branch)
    );

    rv_lsu rv_lsu_inst (
        .i_addr(alu_result), .i_rs2_data(rs2_data), .i_size(mem_size),
        .i_unsigned(load_unsigned), .i_rdata(rdata),
        .o_wdata(lsu_wdata), .o_wen(lsu_wen), .o_load_data(load_data)
    );

    always_comb begin
        case (wb_sel)
            WB_IMM:  wb_data = imm;
            WB_LINK: wb_data = link;  // Return address of JAL and JALR
            WB_LOAD: wb_data = load_data;
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== bench/rv_core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_props
    import rv_core_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_mem_valid,
    input  logic        i_mem_ready,
    input  logic [31:0] i_mem_addr,
    input  logic [31:0] i_mem_data,
    input  logic [3:0]  i_mem_wen,
    input  stage_t      i_stage
);

    // A pending request keeps its address, data and mask until the memory accepts it
    req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_mem_valid && !i_mem_ready) |=> (i_mem_valid && $stable(i_mem_addr) &&
        $stable(i_mem_data) && $stable(i_mem_wen)))
        else $error("memory request changed before ready");

    wen_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_mem_valid |-> (i_mem_wen == 4'b0000))
        else $error("write enable set without valid");

    reset_exit: assert property (@(posedge i_clk) $fell(i_rst) |-> !i_mem_valid)
        else $error("valid high right after reset");

    fetch_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_mem_valid && i_stage == ST_FETCH) |-> (i_mem_addr[1:0] == 2'b00))
        else $error("misaligned fetch address");

endmodule

bind rv_core rv_core_props rv_core_props_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_mem_valid(o_mem_valid), .i_mem_ready(i_mem_ready),
    .i_mem_addr(o_mem_addr), .i_mem_data(o_mem_data), .i_mem_wen(o_mem_wen),
    .i_stage(rv_sequencer_inst.stage)
);

`default_nettype wire

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_defines.svh"
`default_nettype none

module rv_core_tb;

    localparam int MEM_WORDS = 256;
    localparam int NR_TESTS = 6;

    logic                i_clk;
    logic                i_rst;
    logic                i_mem_ready;
    logic [`RV_XLEN-1:0] i_mem_data;
    logic                o_mem_valid;
    logic [`RV_XLEN-1:0] o_mem_addr;
    logic [`RV_XLEN-1:0] o_mem_data;
    logic [3:0]          o_mem_wen;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_wen [$];
    int          exp_test [$];
    int          last_entry [NR_TESTS+1];
    int          test_errs [NR_TESTS+1];
    int          errors;
    int          checks;
    int          tests_done;
    int          tests_failed;
    int          prog_words;
    int          store_idx;
    int          cur_test;
    int          wait_cycles;
    bit          busy;
    bit          first_seen;
    bit          loaded;
    bit          finished;
    bit          aborted;
    logic [31:0] req_addr;
    logic [31:0] req_data;
    logic [3:0]  req_wen;

    rv_core #(.RESET_PC(32'h0)) rv_core_inst (
        .i_clk, .i_rst, .i_mem_ready, .i_mem_data,
        .o_mem_valid, .o_mem_addr, .o_mem_data, .o_mem_wen
    );

    always #50 i_clk = ~i_clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errs[cur_test]++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_test(input int t);
        tests_done++;
        if (test_errs[t] != 0) begin
            tests_failed++;
        end
        $display("test %0d %s with %0d errors", t, (test_errs[t] == 0) ? "ok" : "bad", test_errs[t]);
    endtask

    // P lines give address and word, E lines give address, data, mask and test number
    task automatic load_trace();
        int          fd;
        string       line;
        string       rest;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  w;
        int          t;
        fd = $fopen("bench/rv_core_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file bench/rv_core_trace.txt");
            errors++;
            aborted = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.getc(0) != "#") begin
                    rest = line.substr(1, line.len() - 1);
                    if (line.getc(0) == "P" && $sscanf(rest, "%h %h", a, d) == 2) begin
                        mem[a[9:2]] = d;
                        prog_words++;
                    end else if (line.getc(0) == "E" &&
                                 $sscanf(rest, "%h %h %h %d", a, d, w, t) == 4) begin
                        exp_addr.push_back(a);
                        exp_data.push_back(d);
                        exp_wen.push_back(w);
                        exp_test.push_back(t);
                        last_entry[t] = exp_addr.size() - 1;
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic take_store();
        string tag;
        if (store_idx >= exp_addr.size()) begin
            $display("unexpected store to address %h after the last expected store", req_addr);
            errors++;
            aborted = 1'b1;
        end else begin
            cur_test = exp_test[store_idx];
            tag = $sformatf("test%0d_store%0d", cur_test, store_idx);
            check({tag, "_addr"}, exp_addr[store_idx], req_addr);
            check({tag, "_data"}, exp_data[store_idx], req_data);
            check({tag, "_wen"}, {28'h0, exp_wen[store_idx]}, {28'h0, req_wen});
            for (int b = 0; b < 4; b++) begin
                if (req_wen[b]) mem[req_addr[9:2]][8*b +: 8] = req_data[8*b +: 8];
            end
            if (store_idx == last_entry[cur_test]) report_test(cur_test);
            store_idx++;
            if (store_idx == exp_addr.size()) finished = 1'b1;
        end
    endtask

    task automatic serve_memory();
        if (i_mem_ready) begin
            i_mem_ready = 1'b0; // Handshake completed at this edge
            busy = 1'b0;
            if (req_wen != 4'b0000) take_store();
        end else if (o_mem_valid && !busy) begin
            busy = 1'b1;
            req_addr = o_mem_addr;
            req_data = o_mem_data;
            req_wen = o_mem_wen;
            wait_cycles = $urandom % 4;
            if (!first_seen) begin
                first_seen = 1'b1;
                cur_test = 1;
                check("test1_first_addr", 32'h0, o_mem_addr);
                check("test1_first_wen", 32'h0, {28'h0, o_mem_wen});
                report_test(1);
            end
        end
        if (busy && !i_mem_ready) begin
            if (wait_cycles == 0) begin
                i_mem_ready = 1'b1;
                i_mem_data = mem[req_addr[9:2]];
            end else begin
                wait_cycles--;
            end
        end
    endtask

    always @(posedge i_clk) begin
        #5;
        if (!i_rst) serve_memory();
    end

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_mem_ready = 1'b0;
        i_mem_data = '0;
        void'($urandom(80034));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3}; // Unused words stand out
        end
        load_trace();
        if (!aborted) begin
            repeat (8) @(posedge i_clk);
            #5 i_rst = 1'b0;
            wait (finished || aborted);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_done, tests_failed, checks, errors);
        if (errors == 0 && tests_done == NR_TESTS) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Budget of forty cycles per instruction slot, four times over
    initial begin
        wait (loaded);
        #(40.0 * prog_words * 4 * 100.0);
        $display("timeout after %0d cycles without finishing the trace", 40 * prog_words * 4);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_sequencer.sv
source/rv_core.sv
bench/rv_core_props.sv
bench/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_isa_pkg.sv
      - source/rv_core_pkg.sv
      - source/rv_decoder.sv
      - source/rv_regfile.sv
      - source/rv_alu.sv
      - source/rv_lsu.sv
      - source/rv_sequencer.sv
      - source/rv_core.sv
  - target: test
    files:
      - bench/rv_core_props.sv
      - bench/rv_core_tb.sv

// ==== bench/rv_core_trace.txt ====
# P <address> <word>: program and data image, hex
# E <address> <data> <wen> <test>: expected stores in order, test number in decimal
P 000 20000513
P 004 FF900093
P 008 06400113
P 00C 002081B3
P 010 00352023
P 014 402081B3
P 018 00352023
P 01C 0020A1B3
P 020 00352023
P 024 0020B1B3
P 028 00352023
P 02C 0F00C193
P 030 00352023
P 034 4010D193
P 038 00352023
P 03C 0040D193
P 040 00352023
P 044 002111B3
P 048 00352023
P 04C 0020E1B3
P 050 00352023
P 054 0F017193
P 058 00352023
P 05C 123451B7
P 060 00352023
P 064 00001197
P 068 00352023
P 06C 008001EF
P 070 00052023
P 074 00352023
P 078 08400313
P 07C 004301E7
P 080 00052023
P 084 00052023
P 088 00352023
P 08C 0A500393
P 090 00108463
P 094 00052023
P 098 00208463
P 09C 00752023
P 0A0 00209463
P 0A4 00052023
P 0A8 00109463
P 0AC 00752023
P 0B0 0020C463
P 0B4 00052023
P 0B8 00114463
P 0BC 00752023
P 0C0 00115463
P 0C4 00052023
P 0C8 0020D463
P 0CC 00752023
P 0D0 00116463
P 0D4 00052023
P 0D8 0020E463
P 0DC 00752023
P 0E0 0020F463
P 0E4 00052023
P 0E8 00117463
P 0EC 00752023
P 0F0 89ABD437
P 0F4 DEF40413
P 0F8 00850023
P 0FC 008500A3
P 100 00850123
P 104 008501A3
P 108 00851023
P 10C 00851123
P 110 30000493
P 114 00248183
P 118 00352023
P 11C 00048183
P 120 00352023
P 124 0034C183
P 128 00352023
P 12C 00249183
P 130 00352023
P 134 0024D183
P 138 00352023
P 13C 00049183
P 140 00352023
P 144 0004A183
P 148 00352023
P 14C 0000006F
P 300 80FF017F
E 200 0000005D F 2
E 200 FFFFFF95 F 2
E 200 00000001 F 2
E 200 00000000 F 2
E 200 FFFFFF09 F 2
E 200 FFFFFFFC F 2
E 200 0FFFFFFF F 2
E 200 00000640 F 2
E 200 FFFFFFFD F 2
E 200 00000060 F 2
E 200 12345000 F 3
E 200 00001064 F 3
E 200 00000070 F 3
E 200 00000080 F 3
E 200 000000A5 F 4
E 200 000000A5 F 4
E 200 000000A5 F 4
E 200 000000A5 F 4
E 200 000000A5 F 4
E 200 000000A5 F 4
E 200 EFEFEFEF 1 5
E 201 EFEFEFEF 2 5
E 202 EFEFEFEF 4 5
E 203 EFEFEFEF 8 5
E 200 CDEFCDEF 3 5
E 202 CDEFCDEF C 5
E 200 FFFFFFFF F 6
E 200 0000007F F 6
E 200 00000080 F 6
E 200 FFFF80FF F 6
E 200 000080FF F 6
E 200 0000017F F 6
E 200 80FF017F F 6
